// ==== design/alu_stage.sv ====
module alu_stage (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                iss_valid,
    input  nand_cpu_pkg::alu_op                 iss_op,
    input  logic [nand_cpu_pkg::immdt_w-1:0]    iss_immdt,
    input  logic [nand_cpu_pkg::data_w-1:0]     iss_a,
    input  logic [nand_cpu_pkg::data_w-1:0]     iss_b,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] iss_rw,
    input  logic [core_pkg::tag_w-1:0]          iss_tag,
    output logic                                wb_valid,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] wb_reg,
    output logic [nand_cpu_pkg::data_w-1:0]     wb_data,
    output logic [core_pkg::tag_w-1:0]          wb_tag
);
    import nand_cpu_pkg::*;

    localparam int shamt_w = $clog2(data_w);

    logic [data_w-1:0]  result;
    logic [data_w-1:0]  immdt_sext;
    logic [data_w-1:0]  immdt_zext;
    logic [shamt_w-1:0] shamt;

    assign immdt_sext = {{(data_w - immdt_w){iss_immdt[immdt_w-1]}}, iss_immdt};
    assign immdt_zext = {{(data_w - immdt_w){1'b0}}, iss_immdt};
    assign shamt      = iss_b[shamt_w-1:0];

    always_comb begin
        case (iss_op)
            op_nand: result = ~(iss_a & iss_b);
            op_add:  result = iss_a + iss_b;       // wraps modulo 2^16
            op_addi: result = iss_a + immdt_sext;
            op_shl:  result = iss_a << shamt;
            op_shr:  result = iss_a >> shamt;
            op_li:   result = immdt_zext;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            wb_reg  <= iss_rw;
            wb_data <= result;
            wb_tag  <= iss_tag;
        end
    end

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

    // tags wrap at 16, so no more than 16 instructions may be unretired
    localparam int tag_w = 4;

    localparam int eb_depth_default = 8;

endpackage

// ==== design/dispatch_stage.sv ====
module dispatch_stage (
    input  logic                                instr_valid,
    input  nand_cpu_pkg::alu_op                 instr_op,
    input  logic [nand_cpu_pkg::immdt_w-1:0]    instr_immdt,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_ra,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_rt,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_rw,
    input  logic [core_pkg::tag_w-1:0]          instr_tag,
    output logic                                instr_ready,
    input  logic                                full,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] rd_ra,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] rd_rt,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] rd_rw,
    input  logic [nand_cpu_pkg::data_w-1:0]     ra_data,
    input  logic [nand_cpu_pkg::data_w-1:0]     rt_data,
    input  logic                                ra_pending,
    input  logic                                rt_pending,
    input  logic                                rw_pending,
    output logic                                claim_valid,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] claim_reg,
    input  logic                                wb_valid,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [nand_cpu_pkg::data_w-1:0]     wb_data,
    output logic                                ent_valid,
    output nand_cpu_pkg::alu_op                 ent_op,
    output logic [nand_cpu_pkg::immdt_w-1:0]    ent_immdt,
    output logic [core_pkg::tag_w-1:0]          ent_tag,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] ent_rw,
    output logic [nand_cpu_pkg::data_w-1:0]     ent_a,
    output logic                                ent_a_ready,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] ent_a_reg,
    output logic [nand_cpu_pkg::data_w-1:0]     ent_b,
    output logic                                ent_b_ready,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] ent_b_reg
);
    import nand_cpu_pkg::*;

    logic use_a;
    logic use_b;
    logic wb_hits_a;
    logic wb_hits_b;
    logic accept;

    // returns {ready, value} for one source operand
    function automatic logic [data_w:0] capture(
        input logic              used,
        input logic              src_pending,
        input logic [data_w-1:0] src_data,
        input logic              src_on_wb,
        input logic [data_w-1:0] bus_data
    );
        logic [data_w:0] res;
        if (!used) begin
            res = {1'b1, {data_w{1'b0}}};
        end else if (!src_pending) begin
            res = {1'b1, src_data};
        end else if (src_on_wb) begin
            res = {1'b1, bus_data};
        end else begin
            res = '0;                      // waits in the buffer for the broadcast
        end
        return res;
    endfunction

    assign use_a = (instr_op != op_li);
    assign use_b = (instr_op inside {op_nand, op_add, op_shl, op_shr});

    assign wb_hits_a = wb_valid && (wb_reg == instr_ra);
    assign wb_hits_b = wb_valid && (wb_reg == instr_rt);

    // a pending destination is held back so results match in-order execution
    assign instr_ready = !full && !rw_pending;
    assign accept      = instr_valid && instr_ready;

    assign rd_ra = instr_ra;
    assign rd_rt = instr_rt;
    assign rd_rw = instr_rw;

    assign claim_valid = accept;
    assign claim_reg   = instr_rw;

    assign ent_valid = accept;
    assign ent_op    = instr_op;
    assign ent_immdt = instr_immdt;
    assign ent_tag   = instr_tag;
    assign ent_rw    = instr_rw;
    assign ent_a_reg = instr_ra;
    assign ent_b_reg = instr_rt;

    assign {ent_a_ready, ent_a} = capture(use_a, ra_pending, ra_data, wb_hits_a, wb_data);
    assign {ent_b_ready, ent_b} = capture(use_b, rt_pending, rt_data, wb_hits_b, wb_data);

endmodule

// ==== design/exec_core.sv ====
module exec_core #(
    parameter int eb_depth = core_pkg::eb_depth_default
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                instr_valid,
    input  nand_cpu_pkg::alu_op                 instr_op,
    input  logic [nand_cpu_pkg::immdt_w-1:0]    instr_immdt,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_ra,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_rt,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] instr_rw,
    input  logic [core_pkg::tag_w-1:0]          instr_tag,
    output logic                                instr_ready,
    output logic                                wb_valid,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] wb_reg,
    output logic [nand_cpu_pkg::data_w-1:0]     wb_data,
    output logic [core_pkg::tag_w-1:0]          wb_tag
);
    import nand_cpu_pkg::*;
    import core_pkg::*;

    logic [reg_addr_w-1:0] rd_ra;
    logic [reg_addr_w-1:0] rd_rt;
    logic [reg_addr_w-1:0] rd_rw;
    logic [data_w-1:0]     ra_data;
    logic [data_w-1:0]     rt_data;
    logic                  ra_pending;
    logic                  rt_pending;
    logic                  rw_pending;
    logic                  claim_valid;
    logic [reg_addr_w-1:0] claim_reg;

    logic                  ent_valid;
    alu_op                 ent_op;
    logic [immdt_w-1:0]    ent_immdt;
    logic [tag_w-1:0]      ent_tag;
    logic [reg_addr_w-1:0] ent_rw;
    logic [data_w-1:0]     ent_a;
    logic                  ent_a_ready;
    logic [reg_addr_w-1:0] ent_a_reg;
    logic [data_w-1:0]     ent_b;
    logic                  ent_b_ready;
    logic [reg_addr_w-1:0] ent_b_reg;
    logic                  full;

    logic                  iss_valid;
    alu_op                 iss_op;
    logic [immdt_w-1:0]    iss_immdt;
    logic [data_w-1:0]     iss_a;
    logic [data_w-1:0]     iss_b;
    logic [reg_addr_w-1:0] iss_rw;
    logic [tag_w-1:0]      iss_tag;

    register_file u_register_file (.*);

    dispatch_stage u_dispatch_stage (.*);

    execution_buffer #(
        .eb_depth(eb_depth)
    ) u_execution_buffer (.*);

    alu_stage u_alu_stage (.*);

endmodule

// ==== design/execution_buffer.sv ====
module execution_buffer #(
    parameter int eb_depth = core_pkg::eb_depth_default
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                ent_valid,
    input  nand_cpu_pkg::alu_op                 ent_op,
    input  logic [nand_cpu_pkg::immdt_w-1:0]    ent_immdt,
    input  logic [core_pkg::tag_w-1:0]          ent_tag,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] ent_rw,
    input  logic [nand_cpu_pkg::data_w-1:0]     ent_a,
    input  logic                                ent_a_ready,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] ent_a_reg,
    input  logic [nand_cpu_pkg::data_w-1:0]     ent_b,
    input  logic                                ent_b_ready,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] ent_b_reg,
    input  logic                                wb_valid,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [nand_cpu_pkg::data_w-1:0]     wb_data,
    output logic                                full,
    output logic                                iss_valid,
    output nand_cpu_pkg::alu_op                 iss_op,
    output logic [nand_cpu_pkg::immdt_w-1:0]    iss_immdt,
    output logic [nand_cpu_pkg::data_w-1:0]     iss_a,
    output logic [nand_cpu_pkg::data_w-1:0]     iss_b,
    output logic [nand_cpu_pkg::reg_addr_w-1:0] iss_rw,
    output logic [core_pkg::tag_w-1:0]          iss_tag
);
    import nand_cpu_pkg::*;
    import core_pkg::*;

    localparam int idx_w = $clog2(eb_depth);

    typedef struct packed {
        alu_op                 op;
        logic [immdt_w-1:0]    immdt;
        logic [tag_w-1:0]      tag;
        logic [reg_addr_w-1:0] rw;
        logic [data_w-1:0]     a;
        logic                  a_ready;
        logic [reg_addr_w-1:0] a_reg;
        logic [data_w-1:0]     b;
        logic                  b_ready;
        logic [reg_addr_w-1:0] b_reg;
    } eb_entry;

    eb_entry             entries [eb_depth];
    logic [eb_depth-1:0] valid;
    logic                sel_found;
    logic [idx_w-1:0]    sel_idx;
    logic                free_found;
    logic [idx_w-1:0]    free_idx;

    // walking down from the top leaves the lowest matching index
    always_comb begin
        sel_found  = 1'b0;
        sel_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = eb_depth - 1; i >= 0; i--) begin
            if (valid[i] && entries[i].a_ready && entries[i].b_ready) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
            if (!valid[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    // a slot freed by this cycle's issue is only reused from the next cycle on
    assign full = !free_found;

    assign iss_valid = sel_found;
    assign iss_op    = entries[sel_idx].op;
    assign iss_immdt = entries[sel_idx].immdt;
    assign iss_a     = entries[sel_idx].a;
    assign iss_b     = entries[sel_idx].b;
    assign iss_rw    = entries[sel_idx].rw;
    assign iss_tag   = entries[sel_idx].tag;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid <= '0;
        end else begin
            if (sel_found) begin
                valid[sel_idx] <= 1'b0;
            end
            if (ent_valid) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < eb_depth; i++) begin
            if (wb_valid && !entries[i].a_ready && (entries[i].a_reg == wb_reg)) begin
                entries[i].a       <= wb_data;
                entries[i].a_ready <= 1'b1;
            end
            if (wb_valid && !entries[i].b_ready && (entries[i].b_reg == wb_reg)) begin
                entries[i].b       <= wb_data;
                entries[i].b_ready <= 1'b1;
            end
        end
        // dispatch already caught this cycle's broadcast for the new entry
        if (ent_valid) begin
            entries[free_idx] <= '{
                op:      ent_op,
                immdt:   ent_immdt,
                tag:     ent_tag,
                rw:      ent_rw,
                a:       ent_a,
                a_ready: ent_a_ready,
                a_reg:   ent_a_reg,
                b:       ent_b,
                b_ready: ent_b_ready,
                b_reg:   ent_b_reg
            };
        end
    end

endmodule

// ==== design/nand_cpu.svh ====
`ifndef nand_cpu_svh
`define nand_cpu_svh

// data registers visible to the instruction set
`define num_d_reg 8

`endif

// ==== design/nand_cpu_pkg.sv ====
package nand_cpu_pkg;

`include "nand_cpu.svh"

    localparam int num_d_reg  = `num_d_reg;
    localparam int reg_addr_w = $clog2(num_d_reg);
    localparam int data_w     = 16;
    localparam int immdt_w    = 6;

    // op_li takes no source registers, op_addi takes only ra
    typedef enum logic [2:0] {
        op_nand = 3'd0,
        op_add  = 3'd1,
        op_addi = 3'd2,
        op_shl  = 3'd3,
        op_shr  = 3'd4,
        op_li   = 3'd5
    } alu_op;

endpackage

// ==== design/register_file.sv ====
module register_file (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] rd_ra,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] rd_rt,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] rd_rw,
    input  logic                                claim_valid,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] claim_reg,
    input  logic                                wb_valid,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [nand_cpu_pkg::data_w-1:0]     wb_data,
    output logic [nand_cpu_pkg::data_w-1:0]     ra_data,
    output logic [nand_cpu_pkg::data_w-1:0]     rt_data,
    output logic                                ra_pending,
    output logic                                rt_pending,
    output logic                                rw_pending
);
    import nand_cpu_pkg::*;

    logic [data_w-1:0]    regs [num_d_reg];
    logic [num_d_reg-1:0] pending;

    // reads see the stored state only, the same-cycle writeback is bypassed in dispatch
    assign ra_data    = regs[rd_ra];
    assign rt_data    = regs[rd_rt];
    assign ra_pending = pending[rd_ra];
    assign rt_pending = pending[rd_rt];
    assign rw_pending = pending[rd_rw];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < num_d_reg; i++) begin
                regs[i] <= '0;
            end
            pending <= '0;
        end else begin
            if (wb_valid) begin
                regs[wb_reg]    <= wb_data;
                pending[wb_reg] <= 1'b0;
            end
            // a claimed register is never pending, so it cannot be the writeback target
            if (claim_valid) begin
                pending[claim_reg] <= 1'b1;
            end
        end
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/nand_cpu_pkg.sv
design/core_pkg.sv
design/register_file.sv
design/dispatch_stage.sv
design/execution_buffer.sv
design/alu_stage.sv
design/exec_core.sv
sim/exec_core_checker.sv
sim/exec_core_tb.sv

// ==== sim/exec_core_checker.sv ====
module exec_core_checker (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                wb_valid,
    input  logic                                iss_valid,
    input  nand_cpu_pkg::alu_op                 iss_op,
    input  logic [nand_cpu_pkg::immdt_w-1:0]    iss_immdt,
    input  logic [nand_cpu_pkg::data_w-1:0]     iss_a,
    input  logic [nand_cpu_pkg::data_w-1:0]     iss_b,
    input  logic [nand_cpu_pkg::reg_addr_w-1:0] iss_rw,
    input  logic [core_pkg::tag_w-1:0]          iss_tag,
    input  logic                                full,
    input  logic                                instr_ready
);
    int unsigned err_cnt = 0;

    wb_quiet_after_reset: assert property (@(posedge clk) $rose(n_rst) |-> !wb_valid)
        else begin
            $error("wb_valid high in the first cycle after reset");
            err_cnt++;
        end

    // an issued entry must carry fully written fields
    iss_fields_known: assert property (@(posedge clk) disable iff (!n_rst)
        iss_valid |-> !$isunknown({iss_op, iss_immdt, iss_a, iss_b, iss_rw, iss_tag}))
        else begin
            $error("iss_valid high with an unknown entry field");
            err_cnt++;
        end

    no_ready_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        full |-> !instr_ready)
        else begin
            $error("instr_ready high while the buffer is full");
            err_cnt++;
        end

endmodule

bind exec_core exec_core_checker u_checker (
    .clk(clk), .n_rst(n_rst), .wb_valid(wb_valid), .iss_valid(iss_valid),
    .iss_op(iss_op), .iss_immdt(iss_immdt), .iss_a(iss_a), .iss_b(iss_b),
    .iss_rw(iss_rw), .iss_tag(iss_tag), .full(full), .instr_ready(instr_ready)
);

// ==== sim/exec_core_tb.sv ====
module exec_core_tb;
    import nand_cpu_pkg::*;
    import core_pkg::*;

    localparam int num_instr     = 300;
    localparam int num_tags      = 2 ** tag_w;
    localparam int ready_timeout = 200;
    localparam int tag_timeout   = 200;
    localparam int drain_timeout = 2000;

    logic                  clk;
    logic                  n_rst;
    logic                  instr_valid;
    alu_op                 instr_op;
    logic [immdt_w-1:0]    instr_immdt;
    logic [reg_addr_w-1:0] instr_ra;
    logic [reg_addr_w-1:0] instr_rt;
    logic [reg_addr_w-1:0] instr_rw;
    logic [tag_w-1:0]      instr_tag;
    logic                  instr_ready;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_reg;
    logic [data_w-1:0]     wb_data;
    logic [tag_w-1:0]      wb_tag;

    logic [31:0]           rng;
    logic [reg_addr_w-1:0] last_rw;
    logic [data_w-1:0]     model_regs [num_d_reg];
    logic [data_w-1:0]     wb_image [num_d_reg];    // register state as seen on the writeback bus
    logic                  model_pend [num_d_reg];
    logic                  tag_busy [num_tags];
    logic [reg_addr_w-1:0] exp_reg [num_tags];
    logic [data_w-1:0]     exp_data [num_tags];
    int                    acc_cycle [num_tags];
    int                    cycle_cnt;
    int                    accepted;
    int                    retired;

    exec_core dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [data_w-1:0] alu_model(input alu_op op, input logic [data_w-1:0] a,
                                                    input logic [data_w-1:0] b,
                                                    input logic [immdt_w-1:0] imm);
        case (op)
            op_nand: return ~(a & b);
            op_add:  return a + b;
            op_addi: return a + data_w'($signed(imm));
            op_shl:  return a << b[3:0];
            op_shr:  return a >> b[3:0];
            op_li:   return data_w'(imm);
            default: return '0;
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else
            abort_run($sformatf("[FAIL] t=%0t %s expected %0h actual %0h",
                                $time, sig, expected, actual));
    endtask

    task automatic next_instr(input int seq, input bit chain);
        rng         = xorshift(rng);
        instr_op    = alu_op'(3'(rng % 32'd6));
        instr_immdt = rng[8:3];
        instr_ra    = rng[11:9];
        instr_rt    = rng[14:12];
        instr_rw    = rng[17:15];
        instr_tag   = tag_w'(seq);
        if (chain) begin                    // each one reads the previous destination
            if (instr_op == op_li) begin
                instr_op = op_addi;
            end
            instr_ra = last_rw;
            instr_rw = last_rw + 1'b1;
        end
        if (seq == 0) begin
            instr_op = op_li;
        end
        last_rw = instr_rw;
    endtask

    // the model runs in program order just before the acceptance edge
    task automatic record_accept();
        logic [data_w-1:0] res;
        res = alu_model(instr_op, model_regs[instr_ra], model_regs[instr_rt], instr_immdt);
        model_regs[instr_rw] = res;
        model_pend[instr_rw] = 1'b1;
        exp_reg[instr_tag]   = instr_rw;
        exp_data[instr_tag]  = res;
        acc_cycle[instr_tag] = cycle_cnt;
        tag_busy[instr_tag]  = 1'b1;
        accepted++;
    endtask

    task automatic wait_accept();
        int  waited;
        bit  done;
        waited = 0;
        done   = 0;
        while (!done) begin
            @(negedge clk);
            if (model_pend[instr_rw]) begin
                assert (!instr_ready) else
                    abort_run("instr_ready is high while the destination is still pending");
            end
            if (instr_ready) begin
                done = 1;
            end else begin
                waited++;
                if (waited > ready_timeout) begin
                    abort_run("timed out waiting for instr_ready");
                end
            end
        end
        record_accept();
    endtask

    task automatic wait_tag_free(input int tag);
        int waited;
        waited = 0;
        while (tag_busy[tag]) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > tag_timeout) begin
                abort_run($sformatf("timed out waiting for tag %0d to retire", tag));
            end
        end
    endtask

    always @(negedge clk) begin
        if (n_rst) begin
            assert (dut.u_checker.err_cnt == 0) else
                abort_run("a protocol assertion in the bound checker failed");
            assert (!$isunknown(wb_valid)) else abort_run("wb_valid is unknown");
            if (wb_valid) begin
                assert (tag_busy[wb_tag]) else
                    abort_run($sformatf("writeback for tag %0d which is not in flight", wb_tag));
                check_value("wb_reg", exp_reg[wb_tag], wb_reg);
                check_value("wb_data", exp_data[wb_tag], wb_data);
                assert (cycle_cnt - acc_cycle[wb_tag] >= 2) else
                    abort_run("writeback came less than two cycles after acceptance");
                tag_busy[wb_tag]   = 1'b0;
                model_pend[wb_reg] = 1'b0;
                wb_image[wb_reg]   = wb_data;
                retired++;
            end
        end
    end

    initial begin
        int waited;
        clk         = 1'b0;
        n_rst       = 1'b0;
        instr_valid = 1'b0;
        instr_op    = op_li;
        instr_immdt = '0;
        instr_ra    = '0;
        instr_rt    = '0;
        instr_rw    = '0;
        instr_tag   = '0;
        rng         = 32'ha66b9a2e;
        last_rw     = '0;
        cycle_cnt   = 0;
        accepted    = 0;
        retired     = 0;
        for (int i = 0; i < num_d_reg; i++) begin
            model_regs[i] = '0;
            wb_image[i]   = '0;
            model_pend[i] = 1'b0;
        end
        for (int i = 0; i < num_tags; i++) begin
            tag_busy[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        #1;
        n_rst = 1'b1;
        repeat (3) @(posedge clk);      // idle cycles, no writeback expected here
        #1;

        for (int seq = 0; seq < num_instr; seq++) begin
            wait_tag_free(seq % num_tags);
            next_instr(seq, ((seq / 40) % 2) == 1);
            instr_valid = 1'b1;
            wait_accept();
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            rng = xorshift(rng);
            if (rng[1:0] == 2'b00) begin
                @(posedge clk);
                #1;
            end
        end

        waited = 0;
        while (retired != accepted) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > drain_timeout) begin
                abort_run("timed out waiting for the in-flight instructions to drain");
            end
        end

        for (int i = 0; i < num_d_reg; i++) begin
            check_value($sformatf("final r%0d", i), model_regs[i], wb_image[i]);
        end

        if (dut.u_checker.err_cnt == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "bound checker reported errors");
        end
    end

endmodule
